// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_coh_noc_system
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== common/noc_cpu_pkg.sv ====
// CPU side Wishbone classic types. Full words only, no byte selects
`include "noc_settings.svh"

package noc_cpu_pkg;

    typedef logic [`NOC_ADDR_W-1:0] addr_t;
    typedef logic [`NOC_DATA_W-1:0] data_t;

    // Master to slave
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        data_t dat_w;
    } wb_req_t;

    // Slave to master, ack is a single cycle pulse
    typedef struct packed {
        logic  ack;
        data_t dat_r;
    } wb_rsp_t;

endpackage

// ==== common/noc_flit_pkg.sv ====
// Network side types. One flit carries a whole transaction, no multi-flit packets
`include "noc_settings.svh"

package noc_flit_pkg;

    typedef logic [`NOC_COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } node_xy_t;

    typedef enum logic [1:0] {
        VC_REQ = 2'd0,
        VC_RSP = 2'd1,
        VC_DAT = 2'd2
    } vc_class_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } opcode_e;

    typedef struct packed {
        vc_class_e              vc;
        opcode_e                op;
        node_xy_t               src;
        node_xy_t               dst;
        logic [`NOC_ADDR_W-1:0] addr;
        logic [`NOC_DATA_W-1:0] data;
    } flit_t;

    // Router port numbering, north is +y and east is +x
    localparam int NUM_PORTS  = 5;
    localparam int PORT_LOCAL = 0;
    localparam int PORT_NORTH = 1;
    localparam int PORT_SOUTH = 2;
    localparam int PORT_EAST  = 3;
    localparam int PORT_WEST  = 4;

endpackage

// ==== common/noc_settings.svh ====
// Sizes shared by the mesh, the nodes and the CPU ports
// Router code assumes NOC_COORD_W covers both mesh dimensions
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// Mesh shape
`define NOC_MESH_X 2
`define NOC_MESH_Y 2
`define NOC_COORD_W 1

// CPU word address and data
`define NOC_ADDR_W 12
`define NOC_DATA_W 32

// Words held by each SN-F
`define NOC_MEM_DEPTH 64

// Address bit that picks the SN-F column (word interleave)
`define NOC_HOME_BIT 0

`endif

// ==== hw/coh_noc_system.sv ====
// Two RN-F bridges on the bottom row, two SN-F memories on the top row
// CPU port i maps to the RN-F at (i,0)
`include "noc_settings.svh"

module coh_noc_system (
    input  logic                       clk,
    input  logic                       reset,
    input  noc_cpu_pkg::wb_req_t [1:0] cpu_req,
    output noc_cpu_pkg::wb_rsp_t [1:0] cpu_rsp
);
    import noc_flit_pkg::*;

    localparam int NR      = `NOC_MESH_X * `NOC_MESH_Y;
    localparam int SN_BASE = `NOC_MESH_X * (`NOC_MESH_Y - 1);

    logic [NR-1:0]  local_in_valid;
    flit_t [NR-1:0] local_in_flit;
    logic [NR-1:0]  local_in_ready;
    logic [NR-1:0]  local_out_valid;
    flit_t [NR-1:0] local_out_flit;
    logic [NR-1:0]  local_out_ready;

    noc_mesh i_mesh (
        .clk             (clk),
        .reset           (reset),
        .local_in_valid  (local_in_valid),
        .local_in_flit   (local_in_flit),
        .local_in_ready  (local_in_ready),
        .local_out_valid (local_out_valid),
        .local_out_flit  (local_out_flit),
        .local_out_ready (local_out_ready)
    );

    // RN-F at (i,0), sends REQ and takes RSP or DAT
    for (genvar i = 0; i < 2; i++) begin : g_rn_f
        rn_f_bridge #(
            .MY_XY ({coord_t'(i), coord_t'(0)})
        ) i_rn_f (
            .clk       (clk),
            .reset     (reset),
            .wb_req    (cpu_req[i]),
            .wb_rsp    (cpu_rsp[i]),
            .req_valid (local_in_valid[i]),
            .req_flit  (local_in_flit[i]),
            .req_ready (local_in_ready[i]),
            .rsp_valid (local_out_valid[i]),
            .rsp_flit  (local_out_flit[i]),
            .rsp_ready (local_out_ready[i])
        );
    end

    // SN-F at (i,1), takes REQ and answers
    for (genvar i = 0; i < 2; i++) begin : g_sn_f
        sn_f_memory #(
            .MY_XY ({coord_t'(i), coord_t'(`NOC_MESH_Y - 1)})
        ) i_sn_f (
            .clk       (clk),
            .reset     (reset),
            .req_valid (local_out_valid[SN_BASE + i]),
            .req_flit  (local_out_flit[SN_BASE + i]),
            .req_ready (local_out_ready[SN_BASE + i]),
            .rsp_valid (local_in_valid[SN_BASE + i]),
            .rsp_flit  (local_in_flit[SN_BASE + i]),
            .rsp_ready (local_in_ready[SN_BASE + i])
        );
    end

endmodule

// ==== hw/mesh/noc_mesh.sv ====
// Mesh of XY routers, local ports indexed x + NOC_MESH_X * y
// Edge links are tied off, XY routing never sends a flit off the mesh
`include "noc_settings.svh"

module noc_mesh (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic [`NOC_MESH_X*`NOC_MESH_Y-1:0]                    local_in_valid,
    input  noc_flit_pkg::flit_t [`NOC_MESH_X*`NOC_MESH_Y-1:0]     local_in_flit,
    output logic [`NOC_MESH_X*`NOC_MESH_Y-1:0]                    local_in_ready,
    output logic [`NOC_MESH_X*`NOC_MESH_Y-1:0]                    local_out_valid,
    output noc_flit_pkg::flit_t [`NOC_MESH_X*`NOC_MESH_Y-1:0]     local_out_flit,
    input  logic [`NOC_MESH_X*`NOC_MESH_Y-1:0]                    local_out_ready
);
    import noc_flit_pkg::*;

    localparam int MX = `NOC_MESH_X;
    localparam int MY = `NOC_MESH_Y;
    localparam int NR = MX * MY;

    logic [NUM_PORTS-1:0]  rt_in_valid  [NR];
    flit_t [NUM_PORTS-1:0] rt_in_flit   [NR];
    logic [NUM_PORTS-1:0]  rt_in_ready  [NR];
    logic [NUM_PORTS-1:0]  rt_out_valid [NR];
    flit_t [NUM_PORTS-1:0] rt_out_flit  [NR];
    logic [NUM_PORTS-1:0]  rt_out_ready [NR];

    for (genvar r = 0; r < NR; r++) begin : g_router
        noc_router #(
            .MY_X (coord_t'(r % MX)),
            .MY_Y (coord_t'(r / MX))
        ) i_router (
            .clk       (clk),
            .reset     (reset),
            .in_valid  (rt_in_valid[r]),
            .in_flit   (rt_in_flit[r]),
            .in_ready  (rt_in_ready[r]),
            .out_valid (rt_out_valid[r]),
            .out_flit  (rt_out_flit[r]),
            .out_ready (rt_out_ready[r])
        );
    end

    // =========================================================
    // Forward path, valid and flit
    // =========================================================

    always_comb begin
        int x;
        int y;
        for (int r = 0; r < NR; r++) begin
            x = r % MX;
            y = r / MX;
            rt_in_valid[r] = '0;
            rt_in_flit[r]  = '0;
            rt_in_valid[r][PORT_LOCAL] = local_in_valid[r];
            rt_in_flit[r][PORT_LOCAL]  = local_in_flit[r];
            local_out_valid[r] = rt_out_valid[r][PORT_LOCAL];
            local_out_flit[r]  = rt_out_flit[r][PORT_LOCAL];
            // Each neighbor feeds us from its opposite port
            if (y < MY - 1) begin
                rt_in_valid[r][PORT_NORTH] = rt_out_valid[r + MX][PORT_SOUTH];
                rt_in_flit[r][PORT_NORTH]  = rt_out_flit[r + MX][PORT_SOUTH];
            end
            if (y > 0) begin
                rt_in_valid[r][PORT_SOUTH] = rt_out_valid[r - MX][PORT_NORTH];
                rt_in_flit[r][PORT_SOUTH]  = rt_out_flit[r - MX][PORT_NORTH];
            end
            if (x < MX - 1) begin
                rt_in_valid[r][PORT_EAST] = rt_out_valid[r + 1][PORT_WEST];
                rt_in_flit[r][PORT_EAST]  = rt_out_flit[r + 1][PORT_WEST];
            end
            if (x > 0) begin
                rt_in_valid[r][PORT_WEST] = rt_out_valid[r - 1][PORT_EAST];
                rt_in_flit[r][PORT_WEST]  = rt_out_flit[r - 1][PORT_EAST];
            end
        end
    end

    // =========================================================
    // Backward path, ready
    // =========================================================

    always_comb begin
        int x;
        int y;
        for (int r = 0; r < NR; r++) begin
            x = r % MX;
            y = r / MX;
            rt_out_ready[r] = '1;
            rt_out_ready[r][PORT_LOCAL] = local_out_ready[r];
            local_in_ready[r] = rt_in_ready[r][PORT_LOCAL];
            if (y < MY - 1) rt_out_ready[r][PORT_NORTH] = rt_in_ready[r + MX][PORT_SOUTH];
            if (y > 0) rt_out_ready[r][PORT_SOUTH] = rt_in_ready[r - MX][PORT_NORTH];
            if (x < MX - 1) rt_out_ready[r][PORT_EAST] = rt_in_ready[r + 1][PORT_WEST];
            if (x > 0) rt_out_ready[r][PORT_WEST] = rt_in_ready[r - 1][PORT_EAST];
        end
    end

endmodule

// ==== hw/mesh/noc_router.sv ====
// XY router with one output register per port and no input buffering
// An output register loads only when empty, so each port moves a flit every other cycle

module noc_router #(
    parameter noc_flit_pkg::coord_t MY_X = '0,
    parameter noc_flit_pkg::coord_t MY_Y = '0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [4:0]                in_valid,
    input  noc_flit_pkg::flit_t [4:0] in_flit,
    output logic [4:0]                in_ready,
    output logic [4:0]                out_valid,
    output noc_flit_pkg::flit_t [4:0] out_flit,
    input  logic [4:0]                out_ready
);
    import noc_flit_pkg::*;

    typedef logic [2:0] port_t;

    port_t                route   [NUM_PORTS];
    logic [NUM_PORTS-1:0] req     [NUM_PORTS];
    logic [NUM_PORTS-1:0] gnt     [NUM_PORTS];
    port_t                gnt_idx [NUM_PORTS];
    port_t                rr_ptr  [NUM_PORTS];
    logic [NUM_PORTS-1:0] out_valid_q;
    flit_t [NUM_PORTS-1:0] out_flit_q;

    // =========================================================
    // Route computation
    // =========================================================

    // X first, then Y
    function automatic port_t xy_route(node_xy_t dst);
        port_t p;
        if (dst.x > MY_X) p = port_t'(PORT_EAST);
        else if (dst.x < MY_X) p = port_t'(PORT_WEST);
        else if (dst.y > MY_Y) p = port_t'(PORT_NORTH);
        else if (dst.y < MY_Y) p = port_t'(PORT_SOUTH);
        else p = port_t'(PORT_LOCAL);
        return p;
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            route[i] = xy_route(in_flit[i].dst);
        end
    end

    // req[o][i]: input i wants output o
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                req[o][i] = in_valid[i] && (route[i] == port_t'(o));
            end
        end
    end

    // =========================================================
    // Round-robin arbitration per output
    // =========================================================

    always_comb begin
        int   idx;
        logic found;
        for (int o = 0; o < NUM_PORTS; o++) begin
            gnt[o]     = '0;
            gnt_idx[o] = '0;
            found      = 1'b0;
            // Search starts just after the last winner
            for (int k = 1; k <= NUM_PORTS; k++) begin
                idx = (int'(rr_ptr[o]) + k) % NUM_PORTS;
                if (!found && req[o][idx]) begin
                    gnt[o][idx] = 1'b1;
                    gnt_idx[o]  = port_t'(idx);
                    found       = 1'b1;
                end
            end
        end
    end

    // Winner is taken only when its output register is empty
    always_comb begin
        in_ready = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (gnt[o][i] && !out_valid_q[o]) in_ready[i] = 1'b1;
            end
        end
    end

    // =========================================================
    // Output registers
    // =========================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_q <= '0;
            for (int o = 0; o < NUM_PORTS; o++) begin
                rr_ptr[o] <= port_t'(NUM_PORTS - 1);
            end
        end else begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (out_valid_q[o]) begin
                    if (out_ready[o]) out_valid_q[o] <= 1'b0;
                end else if (|gnt[o]) begin
                    out_valid_q[o] <= 1'b1;
                    rr_ptr[o]      <= gnt_idx[o];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (!out_valid_q[o] && |gnt[o]) out_flit_q[o] <= in_flit[gnt_idx[o]];
        end
    end

    assign out_valid = out_valid_q;
    assign out_flit  = out_flit_q;

    // Downstream may stall, the offered flit must not change under it
    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_hold_chk
        a_out_hold: assert property (@(posedge clk) disable iff (reset)
            out_valid[o] && !out_ready[o] |=> out_valid[o] && $stable(out_flit[o]));
    end

endmodule

// ==== hw/nodes/rn_f_bridge.sv ====
// Wishbone classic slave to request flit bridge, one transaction in flight
// SN-Fs are assumed to sit on the top mesh row, column picked by NOC_HOME_BIT
`include "noc_settings.svh"

module rn_f_bridge #(
    parameter noc_flit_pkg::node_xy_t MY_XY = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  noc_cpu_pkg::wb_req_t wb_req,
    output noc_cpu_pkg::wb_rsp_t wb_rsp,
    output logic                 req_valid,
    output noc_flit_pkg::flit_t  req_flit,
    input  logic                 req_ready,
    input  logic                 rsp_valid,
    input  noc_flit_pkg::flit_t  rsp_flit,
    output logic                 rsp_ready
);
    import noc_flit_pkg::*;
    import noc_cpu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT,
        ACK
    } state_e;

    state_e   state_q;
    flit_t    req_flit_q;
    data_t    rdata_q;
    node_xy_t home_xy;
    logic     start;

    assign start = (state_q == IDLE) && wb_req.cyc && wb_req.stb;

    // Target SN-F for this address
    assign home_xy.x = coord_t'(wb_req.adr[`NOC_HOME_BIT]);
    assign home_xy.y = coord_t'(`NOC_MESH_Y - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: if (start) state_q <= SEND;
                SEND: if (req_ready) state_q <= WAIT;
                WAIT: if (rsp_valid) state_q <= ACK;
                ACK: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_flit_q.vc   <= VC_REQ;
            req_flit_q.op   <= wb_req.we ? OP_WRITE : OP_READ;
            req_flit_q.src  <= MY_XY;
            req_flit_q.dst  <= home_xy;
            req_flit_q.addr <= wb_req.adr;
            req_flit_q.data <= wb_req.dat_w;
        end
        // Answer data, meaningful on reads only
        if (state_q == WAIT && rsp_valid) rdata_q <= rsp_flit.data;
    end

    assign req_valid    = (state_q == SEND);
    assign req_flit     = req_flit_q;
    assign rsp_ready    = (state_q == WAIT);
    assign wb_rsp.ack   = (state_q == ACK);
    assign wb_rsp.dat_r = rdata_q;

    // Mesh must steer REQ traffic to SN-Fs only
    a_no_req_in: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> rsp_flit.vc != VC_REQ);

endmodule

// ==== hw/nodes/sn_f_memory.sv ====
// Word memory node, one request served at a time
// Index uses the address bits just above NOC_HOME_BIT, higher bits alias
`include "noc_settings.svh"

module sn_f_memory #(
    parameter noc_flit_pkg::node_xy_t MY_XY = '0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    input  noc_flit_pkg::flit_t req_flit,
    output logic                req_ready,
    output logic                rsp_valid,
    output noc_flit_pkg::flit_t rsp_flit,
    input  logic                rsp_ready
);
    import noc_flit_pkg::*;

    localparam int IDX_W = $clog2(`NOC_MEM_DEPTH);

    typedef logic [IDX_W-1:0] mem_idx_t;

    logic [`NOC_DATA_W-1:0] mem [`NOC_MEM_DEPTH];
    mem_idx_t               idx;
    logic                   accept;
    logic                   rsp_valid_q;
    flit_t                  rsp_flit_q;

    assign idx       = req_flit.addr[`NOC_HOME_BIT + 1 +: IDX_W];
    assign req_ready = !rsp_valid_q;
    assign accept    = req_valid && req_ready;

    // Busy from acceptance until the reply leaves
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid_q <= 1'b0;
        end else if (accept) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (req_flit.op == OP_WRITE) mem[idx] <= req_flit.data;
            // Writes get RSP, reads get DAT
            rsp_flit_q.vc   <= (req_flit.op == OP_WRITE) ? VC_RSP : VC_DAT;
            rsp_flit_q.op   <= req_flit.op;
            rsp_flit_q.src  <= MY_XY;
            rsp_flit_q.dst  <= req_flit.src;
            rsp_flit_q.addr <= req_flit.addr;
            rsp_flit_q.data <= (req_flit.op == OP_WRITE) ? req_flit.data : mem[idx];
        end
    end

    assign rsp_valid = rsp_valid_q;
    assign rsp_flit  = rsp_flit_q;

    // Only requests addressed to this node may arrive here
    a_req_routed: assert property (@(posedge clk) disable iff (reset)
        accept |-> (req_flit.vc == VC_REQ) && (req_flit.dst == MY_XY));

endmodule

// ==== verification/tb_noc_vectors.svh ====
// Directed rows for the two CPU ports, random rows are appended by the testbench
// Addresses stay below 2 * NOC_MEM_DEPTH and reads only hit words written by earlier rows
// addr_t and data_t must be in scope where this is included
`ifndef TB_NOC_VECTORS_SVH
`define TB_NOC_VECTORS_SVH

typedef enum logic [1:0] {
    OP_IDLE,
    OP_WR,
    OP_RD
} cpu_op_e;

// One operation on one port, dat only matters for writes
typedef struct packed {
    cpu_op_e op;
    addr_t   adr;
    data_t   dat;
} cpu_op_t;

typedef struct packed {
    cpu_op_t p0;
    cpu_op_t p1;
} vec_row_t;

localparam int NUM_DIRECTED = 12;

// Columns: port 0 {op, adr, dat}, port 1 {op, adr, dat}
localparam vec_row_t DIRECTED_ROWS [NUM_DIRECTED] = '{
    // Write then read back on port 0
    '{'{OP_WR,   12'h010, 32'h1111_0010}, '{OP_IDLE, 12'h000, 32'h0000_0000}},
    '{'{OP_RD,   12'h010, 32'h0000_0000}, '{OP_IDLE, 12'h000, 32'h0000_0000}},
    // Port 0 writes both SN-Fs, port 1 reads them back
    '{'{OP_WR,   12'h020, 32'hA5A5_0020}, '{OP_IDLE, 12'h000, 32'h0000_0000}},
    '{'{OP_WR,   12'h021, 32'h5A5A_0021}, '{OP_IDLE, 12'h000, 32'h0000_0000}},
    '{'{OP_IDLE, 12'h000, 32'h0000_0000}, '{OP_RD,   12'h020, 32'h0000_0000}},
    '{'{OP_IDLE, 12'h000, 32'h0000_0000}, '{OP_RD,   12'h021, 32'h0000_0000}},
    // Both ports on SN-F 0 in the same row
    '{'{OP_WR,   12'h030, 32'hC0DE_0030}, '{OP_WR,   12'h032, 32'hBEEF_0032}},
    '{'{OP_RD,   12'h032, 32'h0000_0000}, '{OP_RD,   12'h030, 32'h0000_0000}},
    // Both ports on SN-F 1
    '{'{OP_WR,   12'h041, 32'h0BAD_0041}, '{OP_RD,   12'h021, 32'h0000_0000}},
    '{'{OP_RD,   12'h021, 32'h0000_0000}, '{OP_RD,   12'h041, 32'h0000_0000}},
    // Edge words, one per SN-F
    '{'{OP_WR,   12'h07F, 32'hFFFF_007F}, '{OP_WR,   12'h000, 32'h1234_5678}},
    '{'{OP_RD,   12'h000, 32'h0000_0000}, '{OP_RD,   12'h07F, 32'h0000_0000}}
};

`endif

// ==== verification/tb_coh_noc_system.sv ====
// Testbench for the two-port NoC system that applies one row of paired CPU operations at a time
// Each port waits for its own ack and a row takes a varying number of cycles
`include "noc_settings.svh"

module tb_coh_noc_system;
    import noc_cpu_pkg::*;

    `include "tb_noc_vectors.svh"

    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 10;
    localparam int ROW_CYCLES   = 200;
    localparam int RANDOM_ROWS  = 40;
    // Spans both SN-Fs so that no address aliases inside a memory
    localparam int WORDS        = 2 * `NOC_MEM_DEPTH;

    logic          clk;
    logic          reset;
    wb_req_t [1:0] cpu_req;
    wb_rsp_t [1:0] cpu_rsp;

    vec_row_t    rows [$];
    addr_t       written_addrs [$];
    data_t       ref_mem [addr_t];
    logic        table_ready;

    coh_noc_system i_dut (
        .clk     (clk),
        .reset   (reset),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ========================================================
    // Helpers
    // ========================================================

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_no_ack(input string when_txt);
        for (int p = 0; p < 2; p++) begin
            assert (cpu_rsp[p].ack === 1'b0)
                else fail_now($sformatf("Mismatch cpu_rsp[%0d].ack: got 0x%h, expected 0x0 (%s)",
                                        p, cpu_rsp[p].ack, when_txt));
        end
    endtask

    // Reads pick a word that an earlier row wrote
    function automatic cpu_op_t random_op();
        cpu_op_t     o;
        int unsigned pick;
        pick  = $urandom_range(7);
        o.dat = $urandom;
        o.adr = addr_t'($urandom_range(WORDS - 1));
        if (pick == 0) begin
            o.op = OP_IDLE;
        end else if (pick < 4 || written_addrs.size() == 0) begin
            o.op = OP_WR;
        end else begin
            o.op  = OP_RD;
            o.adr = written_addrs[$urandom_range(written_addrs.size() - 1)];
        end
        return o;
    endfunction

    function automatic void note_writes(input vec_row_t row);
        if (row.p0.op == OP_WR) written_addrs.push_back(row.p0.adr);
        if (row.p1.op == OP_WR) written_addrs.push_back(row.p1.adr);
    endfunction

    task automatic build_table();
        vec_row_t row;
        for (int r = 0; r < NUM_DIRECTED; r++) begin
            rows.push_back(DIRECTED_ROWS[r]);
            note_writes(DIRECTED_ROWS[r]);
        end
        for (int r = 0; r < RANDOM_ROWS; r++) begin
            row.p0 = random_op();
            row.p1 = random_op();
            // One address from both ports only when both read
            if (row.p0.op != OP_IDLE && row.p1.op != OP_IDLE &&
                row.p0.adr == row.p1.adr &&
                !(row.p0.op == OP_RD && row.p1.op == OP_RD)) begin
                row.p1.op = OP_IDLE;
            end
            rows.push_back(row);
            note_writes(row);
        end
    endtask

    // ========================================================
    // One row with both ports starting on the same edge
    // ========================================================

    task automatic run_row(input vec_row_t row, input int row_num);
        cpu_op_t ops [2];
        logic    busy [2];
        data_t   expect_rd [2];
        ops[0] = row.p0;
        ops[1] = row.p1;
        @(posedge clk);
        check_no_ack("between rows");
        for (int p = 0; p < 2; p++) begin
            busy[p]      = (ops[p].op != OP_IDLE);
            expect_rd[p] = '0;
            if (ops[p].op == OP_RD) begin
                assert (ref_mem.exists(ops[p].adr))
                    else fail_now($sformatf("Row %0d port %0d reads 0x%h before any write",
                                            row_num, p, ops[p].adr));
                expect_rd[p] = ref_mem[ops[p].adr];
            end
            if (busy[p]) begin
                cpu_req[p] <= wb_req_t'{cyc: 1'b1, stb: 1'b1, we: (ops[p].op == OP_WR),
                                        adr: ops[p].adr, dat_w: ops[p].dat};
            end
        end
        while (busy[0] || busy[1]) begin
            @(posedge clk);
            for (int p = 0; p < 2; p++) begin
                if (cpu_rsp[p].ack === 1'b1) begin
                    assert (busy[p])
                        else fail_now($sformatf("Row %0d port %0d acked with no cycle open",
                                                row_num, p));
                    if (ops[p].op == OP_RD) begin
                        assert (cpu_rsp[p].dat_r === expect_rd[p])
                            else fail_now($sformatf(
                                "Mismatch cpu_rsp[%0d].dat_r: got 0x%h, expected 0x%h (row %0d)",
                                p, cpu_rsp[p].dat_r, expect_rd[p], row_num));
                    end
                    // Cycle ends on the edge after ack
                    cpu_req[p] <= '0;
                    busy[p] = 1'b0;
                end
            end
        end
        for (int p = 0; p < 2; p++) begin
            if (ops[p].op == OP_WR) ref_mem[ops[p].adr] = ops[p].dat;
        end
    endtask

    // ========================================================
    // Main sequence and watchdog
    // ========================================================

    initial begin : main_seq
        cpu_req     = '0;
        reset       = 1'b1;
        table_ready = 1'b0;
        void'($urandom(28721));
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        // No cycle open yet
        repeat (IDLE_CYCLES) begin
            @(posedge clk);
            check_no_ack("with no cycle started");
        end
        foreach (rows[r]) begin
            run_row(rows[r], r);
        end
        @(posedge clk);
        check_no_ack("after the last row");
        $display("PASS: all tests");
        $finish;
    end

    initial begin : watchdog
        wait (table_ready === 1'b1);
        repeat (RESET_CYCLES + IDLE_CYCLES + (rows.size() + 1) * ROW_CYCLES) @(posedge clk);
        fail_now($sformatf("Timeout: a transfer never completed within %0d cycles per row",
                           ROW_CYCLES));
    end

endmodule

// ==== vlog.f ====
+incdir+common
+incdir+verification
common/noc_flit_pkg.sv
common/noc_cpu_pkg.sv
hw/mesh/noc_router.sv
hw/mesh/noc_mesh.sv
hw/nodes/rn_f_bridge.sv
hw/nodes/sn_f_memory.sv
hw/coh_noc_system.sv
verification/tb_coh_noc_system.sv
